/* ram_tp_nc.sv */
`timescale 1ns/1ps

module ram_tp_nc #(
    parameter int ADDR_BITS = $bits(wr_reorder_pkg::slot_t),
    parameter int DATA_BITS = $bits(wr_reorder_pkg::resp_t)
) (
    input  logic                 clk,
    input  logic                 a_we,
    input  logic [ADDR_BITS-1:0] a_addr,
    input  logic [DATA_BITS-1:0] a_data_in,
    input  logic [ADDR_BITS-1:0] b_addr,
    output logic [DATA_BITS-1:0] b_data_out
);
    import wr_reorder_pkg::*;

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [DATA_BITS-1:0] mem [DEPTH];

    // Write port
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_data_in;
        end
    end

    // Registered read port, old data on a same-edge collision
    always_ff @(posedge clk) begin
        b_data_out <= mem[b_addr];
    end

endmodule

/* reorder_buffer_wr.sv */
`timescale 1ns/1ps
`include "wr_reorder_cfg.svh"

module reorder_buffer_wr (
    input  logic    aclk,
    input  logic    aresetn,
    rob_up_if.slice up,
    rob_dn_if.slice dn
);
    import wr_reorder_pkg::*;

    // Slot state
    logic [`WR_N_SLOTS-1:0] busy;
    logic [`WR_N_SLOTS-1:0] done;

    // Issue and release pointers
    slot_t head;
    slot_t tail;

    // Response currently offered upstream
    logic  bvalid_q;
    slot_t bslot_q;

    logic  issue_ok;
    logic  issue;
    logic  stall;
    logic  accept;
    logic  release_slot;
    slot_t rd_addr;

    // ------------------------------------------------------------
    // Issue side
    // ------------------------------------------------------------

    // Every slot from head to head+awlen must be free
    always_comb begin
        issue_ok = 1'b1;
        for (int i = 0; i < `WR_N_BURSTED; i++) begin
            if (up.awlen >= len_t'(i) && busy[slot_t'(head + slot_t'(i))]) begin
                issue_ok = 1'b0;
            end
        end
    end

    assign dn.awvalid = up.awvalid && issue_ok;
    assign dn.awaddr  = up.awaddr;
    assign dn.awlen   = up.awlen;
    assign dn.awslot  = head;

    assign issue      = dn.awvalid && dn.awready;
    assign up.awready = issue;

    // ------------------------------------------------------------
    // Release side
    // ------------------------------------------------------------
    assign stall        = bvalid_q && !up.bready;
    assign accept       = bvalid_q && up.bready;
    assign release_slot = done[tail] && !stall;

    // Hold the read address under stall so bresp stays put
    assign rd_addr = stall ? bslot_q : tail;

    assign up.bvalid = bvalid_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy     <= '0;
            done     <= '0;
            head     <= '0;
            tail     <= '0;
            bvalid_q <= 1'b0;
        end else begin
            // Slot is reusable once upstream took its response
            if (accept) begin
                busy[bslot_q] <= 1'b0;
            end

            if (issue) begin
                head <= head + slot_t'(up.awlen) + slot_t'(1);
                for (int i = 0; i < `WR_N_BURSTED; i++) begin
                    if (up.awlen >= len_t'(i)) begin
                        busy[slot_t'(head + slot_t'(i))] <= 1'b1;
                    end
                end
            end

            if (dn.bvalid) begin
                done[dn.bslot] <= 1'b1;
            end

            // In-order release from the tail
            if (release_slot) begin
                done[tail] <= 1'b0;
                tail       <= tail + slot_t'(1);
            end

            if (!stall) begin
                bvalid_q <= release_slot;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (release_slot) begin
            bslot_q <= tail;
        end
    end

    // Response store, one entry per slot
    ram_tp_nc #(
        .ADDR_BITS ($bits(slot_t)),
        .DATA_BITS ($bits(resp_t))
    ) resp_ram_inst (
        .clk        (aclk),
        .a_we       (dn.bvalid),
        .a_addr     (dn.bslot),
        .a_data_in  (dn.bresp),
        .b_addr     (rd_addr),
        .b_data_out (up.bresp)
    );

endmodule

/* rob_dn_if.sv */
`timescale 1ns/1ps

// Downstream side of one slice: AW out, B in
interface rob_dn_if;
    import wr_reorder_pkg::*;

    addr_t awaddr;
    slot_t awslot;
    len_t  awlen;
    logic  awvalid;
    logic  awready;

    slot_t bslot;
    resp_t bresp;
    logic  bvalid;

    modport slice (
        output awaddr, awslot, awlen, awvalid,
        input  awready, bslot, bresp, bvalid
    );

    modport merge (
        input  awaddr, awslot, awlen, awvalid,
        output awready
    );

    modport steer (
        output bslot, bresp, bvalid
    );

endinterface

/* rob_up_if.sv */
`timescale 1ns/1ps

// Upstream side of one slice: AW in, B out
interface rob_up_if;
    import wr_reorder_pkg::*;

    addr_t awaddr;
    len_t  awlen;
    logic  awvalid;
    logic  awready;

    resp_t bresp;
    logic  bvalid;
    logic  bready;

    modport steer (
        output awaddr, awlen, awvalid,
        input  awready
    );

    modport slice (
        input  awaddr, awlen, awvalid, bready,
        output awready, bresp, bvalid
    );

    modport merge (
        input  bresp, bvalid,
        output bready
    );

endinterface

/* tb_wr_reorder.sv */
`timescale 1ns/1ps

module tb_wr_reorder;
    import wr_reorder_pkg::*;

    localparam int N_ROWS         = 31;
    localparam int TIMEOUT_CYCLES = 200 * N_ROWS + 200;

    logic       aclk = 1'b0;
    logic       aresetn;
    addr_t      s_awaddr;
    stream_id_t s_awid;
    len_t       s_awlen;
    logic       s_awvalid;
    logic       s_awready;
    stream_id_t s_bid;
    resp_t      s_bresp;
    logic       s_bvalid;
    logic       s_bready;
    addr_t      m_awaddr;
    dn_id_t     m_awid;
    len_t       m_awlen;
    logic       m_awvalid;
    logic       m_awready;
    dn_id_t     m_bid;
    resp_t      m_bresp;
    logic       m_bvalid;
    logic       m_bready;

    // Stimulus table, one row per upstream request
    int         tbl_test   [N_ROWS];
    int         tbl_stream [N_ROWS];
    addr_t      tbl_addr   [N_ROWS];
    int         tbl_len    [N_ROWS];
    int         tbl_beats  [N_ROWS];
    int         tbl_hold   [N_ROWS];
    logic [7:0] tbl_bpat   [N_ROWS];
    int         n_rows;

    // Subordinate model state
    dn_id_t     pool_id   [$];
    resp_t      pool_resp [$];
    int         pool_age  [$];
    int         elig      [$];
    int         pick;
    dn_id_t     new_id;
    int         sub_hold;

    logic [7:0] bready_pat;
    logic [2:0] bcyc;
    int         cycles;
    int         beats_sum;
    logic       test_end;
    int         test_num;
    int         test_beats_exp;
    logic       chk_idle;
    int         err_total;
    int         tests_run;
    int         tests_failed;

    wr_reorder_top wr_reorder_top_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_awaddr  (s_awaddr),
        .s_awid    (s_awid),
        .s_awlen   (s_awlen),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_bid     (s_bid),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .m_awaddr  (m_awaddr),
        .m_awid    (m_awid),
        .m_awlen   (m_awlen),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .m_bid     (m_bid),
        .m_bresp   (m_bresp),
        .m_bvalid  (m_bvalid),
        .m_bready  (m_bready)
    );

    wr_reorder_checker wr_reorder_checker_inst (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .s_awaddr       (s_awaddr),
        .s_awid         (s_awid),
        .s_awlen        (s_awlen),
        .s_awvalid      (s_awvalid),
        .s_awready      (s_awready),
        .s_bid          (s_bid),
        .s_bresp        (s_bresp),
        .s_bvalid       (s_bvalid),
        .s_bready       (s_bready),
        .m_awaddr       (m_awaddr),
        .m_awid         (m_awid),
        .m_awlen        (m_awlen),
        .m_awvalid      (m_awvalid),
        .m_awready      (m_awready),
        .m_bready       (m_bready),
        .test_end       (test_end),
        .test_num       (test_num),
        .test_beats_exp (test_beats_exp),
        .idle           (chk_idle),
        .err_total      (err_total),
        .tests_run      (tests_run),
        .tests_failed   (tests_failed)
    );

    initial begin
        forever #5 aclk = ~aclk;
    end

    task automatic add_row(input int test, input int stream, input addr_t addr, input int len,
                           input int beats, input int hold, input logic [7:0] bpat);
        tbl_test[n_rows]   = test;
        tbl_stream[n_rows] = stream;
        tbl_addr[n_rows]   = addr;
        tbl_len[n_rows]    = len;
        tbl_beats[n_rows]  = beats;
        tbl_hold[n_rows]   = hold;
        tbl_bpat[n_rows]   = bpat;
        n_rows++;
    endtask

    // ------------------------------------------------------------
    // Table: test, stream, address, awlen, beats, hold, bready
    // ------------------------------------------------------------
    task automatic build_table();
        n_rows = 0;
        // Test 2, shuffled responses on one stream
        add_row(2, 1, 40'h1000, 0, 1, 6, 8'hff);
        add_row(2, 1, 40'h1010, 0, 1, 6, 8'hff);
        add_row(2, 1, 40'h1020, 0, 1, 6, 8'hff);
        add_row(2, 1, 40'h1030, 0, 1, 6, 8'hff);
        add_row(2, 1, 40'h1010, 0, 1, 6, 8'hff);
        // Test 3, bursts
        add_row(3, 2, 40'h2020, 1, 2, 3, 8'hff);
        add_row(3, 2, 40'h2030, 1, 2, 3, 8'hff);
        add_row(3, 2, 40'h2000, 0, 1, 3, 8'hff);
        add_row(3, 2, 40'h2010, 1, 2, 3, 8'hff);
        // Test 4, more requests than slots while responses are held
        add_row(4, 0, 40'h3000, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3010, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3020, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3030, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3040, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3050, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3060, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3070, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3080, 0, 1, 30, 8'hff);
        add_row(4, 0, 40'h3090, 0, 1, 30, 8'hff);
        // Test 5, upstream stalls
        add_row(5, 3, 40'h4010, 0, 1, 2, 8'h11);
        add_row(5, 3, 40'h4020, 1, 2, 2, 8'h11);
        add_row(5, 3, 40'h4030, 0, 1, 2, 8'h11);
        add_row(5, 3, 40'h4000, 1, 2, 2, 8'h11);
        // Test 6, all streams interleaved, some bursts wrap the slot ring
        add_row(6, 0, 40'h5010, 1, 2, 4, 8'hb7);
        add_row(6, 1, 40'h5020, 0, 1, 4, 8'hb7);
        add_row(6, 2, 40'h5030, 1, 2, 4, 8'hb7);
        add_row(6, 3, 40'h5000, 0, 1, 4, 8'hb7);
        add_row(6, 0, 40'h5020, 0, 1, 4, 8'hb7);
        add_row(6, 1, 40'h5030, 1, 2, 4, 8'hb7);
        add_row(6, 2, 40'h5000, 0, 1, 4, 8'hb7);
        add_row(6, 3, 40'h5010, 1, 2, 4, 8'hb7);
    endtask

    task automatic apply_row(input int e);
        logic accepted;
        sub_hold   = tbl_hold[e];
        bready_pat = tbl_bpat[e];
        s_awid     = stream_id_t'(tbl_stream[e]);
        s_awaddr   = tbl_addr[e];
        s_awlen    = len_t'(tbl_len[e]);
        s_awvalid  = 1'b1;
        beats_sum  = beats_sum + tbl_beats[e];
        accepted   = 1'b0;
        while (!accepted) begin
            @(negedge aclk);
            accepted = s_awready;
            @(posedge aclk);
            #1;
        end
        s_awvalid = 1'b0;
    endtask

    // Drain every response, then let the checker close the test
    task automatic end_test(input int num);
        s_awvalid = 1'b0;
        while (!chk_idle) begin
            @(posedge aclk);
            #1;
        end
        test_num       = num;
        test_beats_exp = beats_sum;
        test_end       = 1'b1;
        @(posedge aclk);
        #1;
        test_end  = 1'b0;
        beats_sum = 0;
    endtask

    // ------------------------------------------------------------
    // Subordinate model
    // ------------------------------------------------------------
    always @(negedge aclk) begin
        for (int i = 0; i < pool_age.size(); i++) begin
            pool_age[i] = pool_age[i] + 1;
        end
        if (aresetn && m_awvalid && m_awready) begin
            // One id per slot, slot wraps inside the slice
            for (int k = 0; k <= int'(m_awlen); k++) begin
                new_id.stream = m_awid.stream;
                new_id.slot   = slot_t'(m_awid.slot + slot_t'(k));
                pool_id.push_back(new_id);
                pool_resp.push_back(m_awaddr[5:4]);
                pool_age.push_back(0);
            end
        end
    end

    initial begin
        void'($urandom(32'h06b938c8));
        forever begin
            @(posedge aclk);
            #1;
            m_bvalid = 1'b0;
            elig.delete();
            for (int i = 0; i < pool_id.size(); i++) begin
                if (pool_age[i] >= sub_hold) elig.push_back(i);
            end
            // Idle on about half the cycles so held ids pile up and leave shuffled
            if (elig.size() > 0 && $urandom % 2 == 0) begin
                pick     = elig[$urandom % elig.size()];
                m_bvalid = 1'b1;
                m_bid    = pool_id[pick];
                m_bresp  = pool_resp[pick];
                pool_id.delete(pick);
                pool_resp.delete(pick);
                pool_age.delete(pick);
            end
        end
    end

    // Upstream bready follows the row's 8-cycle pattern
    always begin
        @(posedge aclk);
        #1;
        s_bready = bready_pat[bcyc];
        bcyc     = bcyc + 3'd1;
    end

    initial begin
        cycles = 0;
        do begin
            @(posedge aclk);
            cycles++;
        end while (cycles < TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        s_awaddr       = '0;
        s_awid         = '0;
        s_awlen        = '0;
        s_awvalid      = 1'b0;
        s_bready       = 1'b1;
        m_awready      = 1'b0;
        m_bid          = '0;
        m_bresp        = '0;
        m_bvalid       = 1'b0;
        bready_pat     = 8'hff;
        bcyc           = '0;
        sub_hold       = 0;
        beats_sum      = 0;
        test_end       = 1'b0;
        test_num       = 0;
        test_beats_exp = 0;
        build_table();

        aresetn = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        aresetn = 1'b1;
        @(posedge aclk);
        #1;
        m_awready = 1'b1;

        for (int e = 0; e < N_ROWS; e++) begin
            if (e > 0 && tbl_test[e] != tbl_test[e-1]) end_test(tbl_test[e-1]);
            apply_row(e);
        end
        end_test(tbl_test[N_ROWS-1]);

        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, err_total);
        if (tests_failed == 0 && err_total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* wr_merge.sv */
`timescale 1ns/1ps
`include "wr_reorder_cfg.svh"

module wr_merge (
    input  logic                        aclk,
    input  logic                        aresetn,
    rob_up_if.merge                     up [`WR_N_CH],
    rob_dn_if.merge                     dn [`WR_N_CH],
    output wr_reorder_pkg::addr_t       m_awaddr,
    output wr_reorder_pkg::dn_id_t      m_awid,
    output wr_reorder_pkg::len_t        m_awlen,
    output logic                        m_awvalid,
    input  logic                        m_awready,
    output wr_reorder_pkg::stream_id_t  s_bid,
    output wr_reorder_pkg::resp_t       s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready
);
    import wr_reorder_pkg::*;

    logic [`WR_N_CH-1:0] aw_req;
    addr_t               aw_addr [`WR_N_CH];
    slot_t               aw_slot [`WR_N_CH];
    len_t                aw_len  [`WR_N_CH];
    stream_id_t          aw_last;
    stream_id_t          aw_gnt;

    logic [`WR_N_CH-1:0] b_req;
    resp_t               b_resp [`WR_N_CH];
    stream_id_t          b_last;
    stream_id_t          b_gnt;
    logic                b_hold;
    stream_id_t          b_hold_idx;

    // First requester after the last grant, wrapping around
    function automatic stream_id_t rr_pick(input logic [`WR_N_CH-1:0] req,
                                           input stream_id_t last);
        stream_id_t pick;
        stream_id_t idx;
        pick = last;
        for (int k = `WR_N_CH; k >= 1; k--) begin
            idx = stream_id_t'((int'(last) + k) % `WR_N_CH);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    for (genvar i = 0; i < `WR_N_CH; i++) begin : g_ch
        assign aw_req[i]     = dn[i].awvalid;
        assign aw_addr[i]    = dn[i].awaddr;
        assign aw_slot[i]    = dn[i].awslot;
        assign aw_len[i]     = dn[i].awlen;
        assign dn[i].awready = m_awready && (aw_gnt == stream_id_t'(i));

        assign b_req[i]      = up[i].bvalid;
        assign b_resp[i]     = up[i].bresp;
        assign up[i].bready  = s_bready && (b_gnt == stream_id_t'(i));
    end

    // ------------------------------------------------------------
    // AW arbiter
    // ------------------------------------------------------------
    assign aw_gnt    = rr_pick(aw_req, aw_last);
    assign m_awvalid = aw_req[aw_gnt];
    assign m_awaddr  = aw_addr[aw_gnt];
    assign m_awlen   = aw_len[aw_gnt];
    assign m_awid    = {aw_gnt, aw_slot[aw_gnt]};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            aw_last <= stream_id_t'(`WR_N_CH - 1);
        end else if (m_awvalid && m_awready) begin
            aw_last <= aw_gnt;
        end
    end

    // ------------------------------------------------------------
    // B arbiter, grant locked while upstream stalls
    // ------------------------------------------------------------
    assign b_gnt    = b_hold ? b_hold_idx : rr_pick(b_req, b_last);
    assign s_bvalid = b_req[b_gnt];
    assign s_bid    = b_gnt;
    assign s_bresp  = b_resp[b_gnt];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            b_last     <= stream_id_t'(`WR_N_CH - 1);
            b_hold     <= 1'b0;
            b_hold_idx <= '0;
        end else if (s_bvalid && s_bready) begin
            b_last <= b_gnt;
            b_hold <= 1'b0;
        end else if (s_bvalid) begin
            b_hold     <= 1'b1;
            b_hold_idx <= b_gnt;
        end
    end

endmodule

/* wr_reorder_cfg.svh */
`ifndef WR_REORDER_CFG_SVH
`define WR_REORDER_CFG_SVH

// ------------------------------------------------------------
// Reorder unit sizing
// ------------------------------------------------------------

// Streams, one reorder slice per stream
`define WR_N_CH 4

// Slots per slice
`define WR_N_SLOTS 8

// Largest awlen plus one
`define WR_N_BURSTED 2

`define WR_ADDR_WIDTH 40

`endif

/* wr_reorder_checker.sv */
`timescale 1ns/1ps
`include "wr_reorder_cfg.svh"

module wr_reorder_checker (
    input  logic                        aclk,
    input  logic                        aresetn,
    input  wr_reorder_pkg::addr_t       s_awaddr,
    input  wr_reorder_pkg::stream_id_t  s_awid,
    input  wr_reorder_pkg::len_t        s_awlen,
    input  logic                        s_awvalid,
    input  logic                        s_awready,
    input  wr_reorder_pkg::stream_id_t  s_bid,
    input  wr_reorder_pkg::resp_t       s_bresp,
    input  logic                        s_bvalid,
    input  logic                        s_bready,
    input  wr_reorder_pkg::addr_t       m_awaddr,
    input  wr_reorder_pkg::dn_id_t      m_awid,
    input  wr_reorder_pkg::len_t        m_awlen,
    input  logic                        m_awvalid,
    input  logic                        m_awready,
    input  logic                        m_bready,
    input  logic                        test_end,
    input  int                          test_num,
    input  int                          test_beats_exp,
    output logic                        idle,
    output int                          err_total,
    output int                          tests_run,
    output int                          tests_failed
);
    import wr_reorder_pkg::*;

    // Expected responses, oldest first, tagged with their stream
    stream_id_t exp_stream [$];
    resp_t      exp_resp [$];

    // Busy slots per stream
    int         outstanding [`WR_N_CH];

    int         test_errs;
    int         test_beats;
    logic       after_reset;
    logic       stall_q;
    stream_id_t bid_q;
    resp_t      bresp_q;
    logic       aw_fire;
    logic       m_fire;
    logic       fits;
    int         idx;

    initial begin
        err_total    = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        test_beats   = 0;
        after_reset  = 1'b0;
        stall_q      = 1'b0;
        idle         = 1'b1;
    end

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        $display("[FAIL] %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
        test_errs++;
    endtask

    task automatic check_outputs_low();
        if (s_awready !== 1'b0) report_value("s_awready", 0, s_awready);
        if (m_awvalid !== 1'b0) report_value("m_awvalid", 0, m_awvalid);
        if (s_bvalid !== 1'b0) report_value("s_bvalid", 0, s_bvalid);
    endtask

    task automatic close_test(input int num, input int beats_exp);
        if (test_beats != beats_exp) begin
            $display("Test %0d saw %0d responses upstream where %0d were expected",
                     num, test_beats, beats_exp);
            test_errs++;
        end
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %0d: FAILED, %0d errors", num, test_errs);
        end else begin
            $display("test %0d: passed, %0d responses checked", num, test_beats);
        end
        err_total  = err_total + test_errs;
        test_errs  = 0;
        test_beats = 0;
    endtask

    // ------------------------------------------------------------
    // AW side: pass-through, slot limit, expected responses
    // ------------------------------------------------------------
    task automatic check_aw();
        aw_fire = s_awvalid && s_awready;
        m_fire  = m_awvalid && m_awready;
        if (aw_fire !== m_fire) report_value("m_awvalid && m_awready", aw_fire, m_fire);
        if (s_awvalid && m_awready) begin
            fits = (outstanding[s_awid] + int'(s_awlen) + 1) <= `WR_N_SLOTS;
            if (s_awready !== fits) report_value("s_awready", fits, s_awready);
        end
        if (m_fire) begin
            if (m_awid.stream !== s_awid) report_value("m_awid[4:3]", s_awid, m_awid.stream);
            if (m_awaddr !== s_awaddr) report_value("m_awaddr", s_awaddr, m_awaddr);
            if (m_awlen !== s_awlen) report_value("m_awlen", s_awlen, m_awlen);
        end
        if (aw_fire) begin
            for (int k = 0; k <= int'(s_awlen); k++) begin
                exp_stream.push_back(s_awid);
                exp_resp.push_back(s_awaddr[5:4]);
            end
            outstanding[s_awid] = outstanding[s_awid] + int'(s_awlen) + 1;
        end
    endtask

    // ------------------------------------------------------------
    // B side: stability under stall, per-stream order
    // ------------------------------------------------------------
    task automatic check_b();
        if (stall_q) begin
            if (s_bvalid !== 1'b1) begin
                $display("Error at %0d ns: s_bvalid dropped while s_bready was low", $time);
                test_errs++;
            end
            if (s_bid !== bid_q) report_value("s_bid", bid_q, s_bid);
            if (s_bresp !== bresp_q) report_value("s_bresp", bresp_q, s_bresp);
        end
        stall_q = s_bvalid && !s_bready;
        bid_q   = s_bid;
        bresp_q = s_bresp;

        if (s_bvalid && s_bready) begin
            test_beats++;
            // Oldest entry of this stream
            idx = -1;
            for (int i = exp_stream.size() - 1; i >= 0; i--) begin
                if (exp_stream[i] == s_bid) idx = i;
            end
            if (idx < 0) begin
                $display("Error at %0d ns: response on stream %0d with no write outstanding",
                         $time, s_bid);
                test_errs++;
            end else begin
                if (s_bresp !== exp_resp[idx]) report_value("s_bresp", exp_resp[idx], s_bresp);
                exp_stream.delete(idx);
                exp_resp.delete(idx);
                outstanding[s_bid] = outstanding[s_bid] - 1;
            end
        end
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge aclk) begin
        // Slices take every response, in reset and out of it
        if (m_bready !== 1'b1) report_value("m_bready", 1, m_bready);
        if (!aresetn) begin
            exp_stream.delete();
            exp_resp.delete();
            for (int i = 0; i < `WR_N_CH; i++) begin
                outstanding[i] = 0;
            end
            stall_q     = 1'b0;
            idle        = 1'b1;
            check_outputs_low();
            after_reset = 1'b1;
        end else if (after_reset) begin
            // First cycle out of reset closes the reset test
            check_outputs_low();
            after_reset = 1'b0;
            close_test(1, 0);
        end else begin
            check_aw();
            check_b();
            idle = (exp_stream.size() == 0);
            if (test_end) close_test(test_num, test_beats_exp);
        end
    end

endmodule

/* wr_reorder_pkg.sv */
`include "wr_reorder_cfg.svh"

package wr_reorder_pkg;

    // ------------------------------------------------------------
    // Id and slot types
    // ------------------------------------------------------------

    // Upstream awid/bid, also selects the slice
    typedef logic [$clog2(`WR_N_CH)-1:0] stream_id_t;

    // Slot index inside one slice
    typedef logic [$clog2(`WR_N_SLOTS)-1:0] slot_t;

    // Downstream id, slice in the upper bits
    typedef struct packed {
        stream_id_t stream;
        slot_t      slot;
    } dn_id_t;

    // ------------------------------------------------------------
    // Payload types
    // ------------------------------------------------------------
    typedef logic [1:0]                  resp_t;
    typedef logic [`WR_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [7:0]                  len_t;

endpackage

/* wr_reorder_top.f */
+incdir+.
wr_reorder_pkg.sv
rob_up_if.sv
rob_dn_if.sv
ram_tp_nc.sv
reorder_buffer_wr.sv
wr_steer.sv
wr_merge.sv
wr_reorder_top.sv
wr_reorder_checker.sv
tb_wr_reorder.sv

/* wr_reorder_top.sv */
`timescale 1ns/1ps
`include "wr_reorder_cfg.svh"

module wr_reorder_top (
    input  logic                        aclk,
    input  logic                        aresetn,

    // Upstream, from the write master
    input  wr_reorder_pkg::addr_t       s_awaddr,
    input  wr_reorder_pkg::stream_id_t  s_awid,
    input  wr_reorder_pkg::len_t        s_awlen,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    output wr_reorder_pkg::stream_id_t  s_bid,
    output wr_reorder_pkg::resp_t       s_bresp,
    output logic                        s_bvalid,
    input  logic                        s_bready,

    // Downstream, to the subordinate
    output wr_reorder_pkg::addr_t       m_awaddr,
    output wr_reorder_pkg::dn_id_t      m_awid,
    output wr_reorder_pkg::len_t        m_awlen,
    output logic                        m_awvalid,
    input  logic                        m_awready,
    input  wr_reorder_pkg::dn_id_t      m_bid,
    input  wr_reorder_pkg::resp_t       m_bresp,
    input  logic                        m_bvalid,
    output logic                        m_bready
);
    import wr_reorder_pkg::*;

    rob_up_if up_if [`WR_N_CH] ();
    rob_dn_if dn_if [`WR_N_CH] ();

    // Slices always accept responses
    assign m_bready = 1'b1;

    wr_steer wr_steer_inst (
        .aclk      (aclk),
        .s_awaddr  (s_awaddr),
        .s_awid    (s_awid),
        .s_awlen   (s_awlen),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .m_bid     (m_bid),
        .m_bresp   (m_bresp),
        .m_bvalid  (m_bvalid),
        .up        (up_if),
        .dn        (dn_if)
    );

    // ------------------------------------------------------------
    // One reorder slice per stream
    // ------------------------------------------------------------
    for (genvar g = 0; g < `WR_N_CH; g++) begin : g_slice
        reorder_buffer_wr reorder_buffer_wr_inst (
            .aclk    (aclk),
            .aresetn (aresetn),
            .up      (up_if[g]),
            .dn      (dn_if[g])
        );
    end

    wr_merge wr_merge_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .up        (up_if),
        .dn        (dn_if),
        .m_awaddr  (m_awaddr),
        .m_awid    (m_awid),
        .m_awlen   (m_awlen),
        .m_awvalid (m_awvalid),
        .m_awready (m_awready),
        .s_bid     (s_bid),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready)
    );

endmodule

/* wr_steer.sv */
`timescale 1ns/1ps
`include "wr_reorder_cfg.svh"

module wr_steer (
    input  logic                        aclk,
    input  wr_reorder_pkg::addr_t       s_awaddr,
    input  wr_reorder_pkg::stream_id_t  s_awid,
    input  wr_reorder_pkg::len_t        s_awlen,
    input  logic                        s_awvalid,
    output logic                        s_awready,
    input  wr_reorder_pkg::dn_id_t      m_bid,
    input  wr_reorder_pkg::resp_t       m_bresp,
    input  logic                        m_bvalid,
    rob_up_if.steer                     up [`WR_N_CH],
    rob_dn_if.steer                     dn [`WR_N_CH]
);
    import wr_reorder_pkg::*;

    // Ready of every slice, selected back by awid
    logic [`WR_N_CH-1:0] aw_ready;

    // ------------------------------------------------------------
    // AW by stream, B by upper id bits
    // ------------------------------------------------------------
    for (genvar i = 0; i < `WR_N_CH; i++) begin : g_ch
        assign up[i].awaddr  = s_awaddr;
        assign up[i].awlen   = s_awlen;
        assign up[i].awvalid = s_awvalid && (s_awid == stream_id_t'(i));
        assign aw_ready[i]   = up[i].awready;

        assign dn[i].bslot   = m_bid.slot;
        assign dn[i].bresp   = m_bresp;
        assign dn[i].bvalid  = m_bvalid && (m_bid.stream == stream_id_t'(i));
    end

    assign s_awready = aw_ready[s_awid];

endmodule
